//--- rtl/blit_pkg.sv
package blit_pkg;

   // data word on both the cpu and the memory side
   typedef logic [15:0] word_t;
   typedef logic [4:0] reg_addr_t;

   // ---------------------------------------------------------------------
   // register window, word offsets
   // ---------------------------------------------------------------------
   localparam reg_addr_t ht_base         = 5'h00;
   localparam reg_addr_t src_x_inc_reg   = 5'h10;
   localparam reg_addr_t src_y_inc_reg   = 5'h11;
   localparam reg_addr_t src_addr_hi_reg = 5'h12;
   localparam reg_addr_t src_addr_lo_reg = 5'h13;
   localparam reg_addr_t endmask1_reg    = 5'h14;
   localparam reg_addr_t endmask2_reg    = 5'h15;
   localparam reg_addr_t endmask3_reg    = 5'h16;
   localparam reg_addr_t dst_x_inc_reg   = 5'h17;
   localparam reg_addr_t dst_y_inc_reg   = 5'h18;
   localparam reg_addr_t dst_addr_hi_reg = 5'h19;
   localparam reg_addr_t dst_addr_lo_reg = 5'h1a;
   localparam reg_addr_t x_count_reg     = 5'h1b;
   localparam reg_addr_t y_count_reg     = 5'h1c;
   localparam reg_addr_t op_reg          = 5'h1d;
   localparam reg_addr_t ctrl_reg        = 5'h1e;

   typedef enum logic [1:0] {
      hop_ones,
      hop_halftone,
      hop_source,
      hop_ht_and_src
   } hop_t;

   // s = source after halftone, d = destination
   typedef enum logic [3:0] {
      lop_zero, lop_s_and_d, lop_s_and_nd, lop_src,
      lop_ns_and_d, lop_dst, lop_xor, lop_or,
      lop_nor, lop_xnor, lop_not_dst, lop_s_or_nd,
      lop_not_src, lop_ns_or_d, lop_nand, lop_ones
   } lop_t;

   // phase of the word being processed
   typedef enum logic [1:0] {
      src_read,
      dst_read,
      dst_write
   } blit_state_t;

   function automatic logic lop_no_src(lop_t op);
      return op inside {lop_zero, lop_dst, lop_not_dst, lop_ones};
   endfunction

   function automatic logic lop_no_dst(lop_t op);
      return op inside {lop_zero, lop_src, lop_not_src, lop_ones};
   endfunction

   function automatic logic hop_no_src(hop_t op);
      return op inside {hop_ones, hop_halftone};
   endfunction

endpackage

//--- rtl/blit_regs.sv
`timescale 1ns/1ps

module blit_regs #(
   parameter int addr_w = 23
) (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  sel,
   input  logic                  rw,
   input  blit_pkg::reg_addr_t   addr,
   input  blit_pkg::word_t       din,
   input  logic                  uds,
   input  logic                  lds,
   output blit_pkg::word_t       dout,
   input  logic                  busy,
   input  logic [3:0]            line_number,
   input  logic [addr_w-1:0]     cur_src_addr,
   input  logic [addr_w-1:0]     cur_dst_addr,
   input  blit_pkg::word_t       cur_x_count,
   input  blit_pkg::word_t       cur_y_count,
   output logic                  start,
   output logic [14:0]           src_x_inc,
   output logic [14:0]           src_y_inc,
   output logic [14:0]           dst_x_inc,
   output logic [14:0]           dst_y_inc,
   output logic [addr_w-1:0]     src_addr_init,
   output logic [addr_w-1:0]     dst_addr_init,
   output blit_pkg::word_t       x_count_init,
   output blit_pkg::word_t       y_count_init,
   output logic [3:0]            line_init,
   output blit_pkg::word_t       endmask1,
   output blit_pkg::word_t       endmask2,
   output blit_pkg::word_t       endmask3,
   output blit_pkg::hop_t        hop,
   output blit_pkg::lop_t        lop,
   output logic [3:0]            skew,
   output blit_pkg::word_t       halftone_line
);
   import blit_pkg::*;

   word_t ht_ram [16];
   logic [addr_w-1:0] src_addr_r;
   logic [addr_w-1:0] dst_addr_r;
   word_t y_count_r;
   logic [3:0] line_r;
   logic busy_d;
   logic live;
   logic wr;

   // engine values are live during the blit and one cycle after,
   // until the copy back below has landed
   assign live = busy | busy_d;
   assign wr = sel & ~rw;

   assign src_addr_init = live ? cur_src_addr : src_addr_r;
   assign dst_addr_init = live ? cur_dst_addr : dst_addr_r;
   assign y_count_init = live ? cur_y_count : y_count_r;
   assign halftone_line = ht_ram[line_number];

   // a ctrl write hands its own line number to the engine it starts
   assign line_init = (wr && addr == ctrl_reg && !uds) ? din[11:8] : line_r;

   // busy bit written high with rows left to do
   assign start = wr && addr == ctrl_reg && !uds && din[15] &&
                  y_count_init != '0 && !busy;

   // ---------------------------------------------------------------------
   // progress registers, copied back from the engine
   // ---------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         busy_d <= 1'b0;
         y_count_r <= '0;
      end else begin
         busy_d <= busy;
         if (live) begin
            src_addr_r <= cur_src_addr;
            dst_addr_r <= cur_dst_addr;
            y_count_r <= cur_y_count;
         end
         // a cpu write wins over the copy
         if (wr) begin
            case (addr)
               src_addr_hi_reg: src_addr_r[addr_w-1:15] <= din[addr_w-16:0];
               src_addr_lo_reg: src_addr_r[14:0] <= din[15:1];
               dst_addr_hi_reg: dst_addr_r[addr_w-1:15] <= din[addr_w-16:0];
               dst_addr_lo_reg: dst_addr_r[14:0] <= din[15:1];
               y_count_reg: y_count_r <= din;
               default: ;
            endcase
         end
      end
   end

   // ---------------------------------------------------------------------
   // programmed fields and halftone ram
   // ---------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (wr) begin
         if (!addr[4]) begin
            ht_ram[addr[3:0]] <= din;
         end else begin
            case (addr)
               src_x_inc_reg: src_x_inc <= din[15:1];
               src_y_inc_reg: src_y_inc <= din[15:1];
               dst_x_inc_reg: dst_x_inc <= din[15:1];
               dst_y_inc_reg: dst_y_inc <= din[15:1];
               endmask1_reg: endmask1 <= din;
               endmask2_reg: endmask2 <= din;
               endmask3_reg: endmask3 <= din;
               x_count_reg: x_count_init <= din;
               // byte registers, uds for d15:d8 and lds for d7:d0
               op_reg: begin
                  if (!uds) hop <= hop_t'(din[9:8]);
                  if (!lds) lop <= lop_t'(din[3:0]);
               end
               ctrl_reg: begin
                  if (!uds) line_r <= din[11:8];
                  if (!lds) skew <= din[3:0];
               end
               default: ;
            endcase
         end
      end
   end

   // read back, zero outside a read cycle
   always_comb begin
      dout = '0;
      if (sel && rw) begin
         if (!addr[4]) begin
            dout = ht_ram[addr[3:0]];
         end else begin
            case (addr)
               src_x_inc_reg: dout = {src_x_inc, 1'b0};
               src_y_inc_reg: dout = {src_y_inc, 1'b0};
               src_addr_hi_reg: dout = word_t'(src_addr_init[addr_w-1:15]);
               src_addr_lo_reg: dout = {src_addr_init[14:0], 1'b0};
               endmask1_reg: dout = endmask1;
               endmask2_reg: dout = endmask2;
               endmask3_reg: dout = endmask3;
               dst_x_inc_reg: dout = {dst_x_inc, 1'b0};
               dst_y_inc_reg: dout = {dst_y_inc, 1'b0};
               dst_addr_hi_reg: dout = word_t'(dst_addr_init[addr_w-1:15]);
               dst_addr_lo_reg: dout = {dst_addr_init[14:0], 1'b0};
               x_count_reg: dout = live ? cur_x_count : x_count_init;
               y_count_reg: dout = y_count_init;
               op_reg: dout = {6'b000000, hop, 4'b0000, lop};
               // hog, smudge, fxsr and nfsr positions stay zero
               ctrl_reg: dout = {busy, 3'b000, line_r, 4'b0000, skew};
               default: dout = '0;
            endcase
         end
      end
   end

endmodule

//--- rtl/blit_sequencer.sv
`timescale 1ns/1ps

module blit_sequencer #(
   parameter int addr_w = 23
) (
   input  logic                     clk,
   input  logic                     reset,
   input  logic                     start,
   input  logic [14:0]              src_x_inc,
   input  logic [14:0]              src_y_inc,
   input  logic [14:0]              dst_x_inc,
   input  logic [14:0]              dst_y_inc,
   input  logic [addr_w-1:0]        src_addr_init,
   input  logic [addr_w-1:0]        dst_addr_init,
   input  blit_pkg::word_t          x_count_init,
   input  blit_pkg::word_t          y_count_init,
   input  logic [3:0]               line_init,
   input  blit_pkg::word_t          endmask1,
   input  blit_pkg::word_t          endmask2,
   input  blit_pkg::word_t          endmask3,
   input  blit_pkg::hop_t           hop,
   input  blit_pkg::lop_t           lop,
   output logic                     busy,
   output blit_pkg::blit_state_t    state,
   output logic [addr_w-1:0]        src_addr,
   output logic [addr_w-1:0]        dst_addr,
   output blit_pkg::word_t          x_count,
   output blit_pkg::word_t          y_count,
   output logic [3:0]               line_number,
   output logic                     first_word,
   output logic                     last_word,
   output logic [addr_w-1:0]        bm_addr,
   output logic                     bm_read,
   output logic                     bm_write,
   output logic                     src_load,
   output logic                     dst_load
);
   import blit_pkg::*;

   logic skip_src;
   logic dst_needed;
   word_t next_x_count;
   blit_state_t next_phase;

   // increments are word steps, sign extended to the bus width
   function automatic logic [addr_w-1:0] sext(logic [14:0] inc);
      return {{(addr_w-15){inc[14]}}, inc};
   endfunction

   // destination read needed for the op or for a partial end mask
   function automatic logic dst_need(logic first, logic last);
      word_t mask;
      mask = first ? endmask1 : (last ? endmask3 : endmask2);
      return !lop_no_dst(lop) || mask != 16'hffff;
   endfunction

   // opening phase of a word at the given row position
   function automatic blit_state_t word_phase(logic first, logic last);
      if (!skip_src)
         return src_read;
      if (dst_need(first, last))
         return dst_read;
      return dst_write;
   endfunction

   assign skip_src = hop_no_src(hop) || lop_no_src(lop);
   assign first_word = x_count == x_count_init;
   assign last_word = x_count == 16'd1;

   // the word after the current write
   assign next_x_count = last_word ? x_count_init : x_count - 16'd1;

   // masks and ops are read inside the functions, so they must wake this block too
   always_comb begin
      dst_needed = dst_need(first_word, last_word);
      next_phase = word_phase(next_x_count == x_count_init, next_x_count == 16'd1);
   end

   // ---------------------------------------------------------------------
   // bus strobes, one clock per access
   // ---------------------------------------------------------------------
   assign bm_read = busy && state != dst_write;
   assign bm_write = busy && state == dst_write;
   assign src_load = busy && state == src_read;
   assign dst_load = busy && state == dst_read;
   assign bm_addr = state == src_read ? src_addr : dst_addr;

   // word phase fsm
   always_ff @(posedge clk) begin
      if (reset) begin
         busy <= 1'b0;
         state <= src_read;
      end else if (start) begin
         busy <= 1'b1;
         state <= word_phase(1'b1, x_count_init == 16'd1);
      end else if (busy) begin
         case (state)
            src_read: state <= dst_needed ? dst_read : dst_write;
            dst_read: state <= dst_write;
            default: begin
               state <= next_phase;
               // done with the write of the last word of the last row
               if (last_word && y_count == 16'd1)
                  busy <= 1'b0;
            end
         endcase
      end
   end

   // ---------------------------------------------------------------------
   // addresses, counters and halftone line
   // ---------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (start) begin
         src_addr <= src_addr_init;
         dst_addr <= dst_addr_init;
         x_count <= x_count_init;
         y_count <= y_count_init;
         line_number <= line_init;
      end else if (busy) begin
         // source steps by y on the last word of a row
         if (state == src_read)
            src_addr <= src_addr + sext(last_word ? src_y_inc : src_x_inc);
         if (state == dst_write) begin
            if (last_word) begin
               dst_addr <= dst_addr + sext(dst_y_inc);
               x_count <= x_count_init;
               y_count <= y_count - 16'd1;
               // line follows the direction of the destination rows
               if (dst_y_inc[14])
                  line_number <= line_number - 4'd1;
               else
                  line_number <= line_number + 4'd1;
            end else begin
               dst_addr <= dst_addr + sext(dst_x_inc);
               x_count <= x_count - 16'd1;
            end
         end
      end
   end

endmodule

//--- rtl/blit_datapath.sv
`timescale 1ns/1ps

module blit_datapath (
   input  logic              clk,
   input  logic              reset,
   input  logic              start,
   input  logic              src_load,
   input  logic              dst_load,
   input  logic              src_x_neg,
   input  blit_pkg::word_t   bm_data_in,
   input  logic [3:0]        skew,
   input  blit_pkg::hop_t    hop,
   input  blit_pkg::lop_t    lop,
   input  blit_pkg::word_t   halftone_line,
   input  blit_pkg::word_t   endmask1,
   input  blit_pkg::word_t   endmask2,
   input  blit_pkg::word_t   endmask3,
   input  logic              first_word,
   input  logic              last_word,
   output blit_pkg::word_t   bm_data_out
);
   import blit_pkg::*;

   logic [31:0] src_buf;
   word_t dst_latch;
   word_t src_skewed;
   word_t src_ht;
   word_t result;
   word_t mask;

   // ---------------------------------------------------------------------
   // capture registers
   // ---------------------------------------------------------------------
   // source words enter on the side the x step walks towards
   always_ff @(posedge clk) begin
      if (reset || start)
         src_buf <= '0;
      else if (src_load)
         src_buf <= src_x_neg ? {bm_data_in, src_buf[31:16]} : {src_buf[15:0], bm_data_in};
   end

   always_ff @(posedge clk) begin
      if (dst_load)
         dst_latch <= bm_data_in;
   end

   // skew picks 16 bits out of the 32-bit window
   assign src_skewed = word_t'(src_buf >> skew);

   // halftone then logic op, dst_latch as second operand
   always_comb begin
      case (hop)
         hop_ones:     src_ht = 16'hffff;
         hop_halftone: src_ht = halftone_line;
         hop_source:   src_ht = src_skewed;
         default:      src_ht = halftone_line & src_skewed;
      endcase

      case (lop)
         lop_zero:     result = 16'h0000;
         lop_s_and_d:  result = src_ht & dst_latch;
         lop_s_and_nd: result = src_ht & ~dst_latch;
         lop_src:      result = src_ht;
         lop_ns_and_d: result = ~src_ht & dst_latch;
         lop_dst:      result = dst_latch;
         lop_xor:      result = src_ht ^ dst_latch;
         lop_or:       result = src_ht | dst_latch;
         lop_nor:      result = ~(src_ht | dst_latch);
         lop_xnor:     result = ~(src_ht ^ dst_latch);
         lop_not_dst:  result = ~dst_latch;
         lop_s_or_nd:  result = src_ht | ~dst_latch;
         lop_not_src:  result = ~src_ht;
         lop_ns_or_d:  result = ~src_ht | dst_latch;
         lop_nand:     result = ~(src_ht & dst_latch);
         default:      result = 16'hffff;
      endcase
   end

   // ---------------------------------------------------------------------
   // end masking
   // ---------------------------------------------------------------------
   // first word wins when a row is a single word
   assign mask = first_word ? endmask1 : (last_word ? endmask3 : endmask2);
   assign bm_data_out = (result & mask) | (dst_latch & ~mask);

endmodule

//--- rtl/blitter_top.sv
`timescale 1ns/1ps

module blitter_top #(
   parameter int addr_w = 23
) (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  sel,
   input  logic                  rw,
   input  blit_pkg::reg_addr_t   addr,
   input  blit_pkg::word_t       din,
   input  logic                  uds,
   input  logic                  lds,
   output blit_pkg::word_t       dout,
   output logic                  irq,
   output logic [addr_w-1:0]     bm_addr,
   output logic                  bm_read,
   output logic                  bm_write,
   output blit_pkg::word_t       bm_data_out,
   input  blit_pkg::word_t       bm_data_in
);
   import blit_pkg::*;

   // programmed fields
   logic start;
   logic [14:0] src_x_inc;
   logic [14:0] src_y_inc;
   logic [14:0] dst_x_inc;
   logic [14:0] dst_y_inc;
   logic [addr_w-1:0] src_addr_init;
   logic [addr_w-1:0] dst_addr_init;
   word_t x_count_init;
   word_t y_count_init;
   logic [3:0] line_init;
   word_t endmask1;
   word_t endmask2;
   word_t endmask3;
   hop_t hop;
   lop_t lop;
   logic [3:0] skew;
   word_t halftone_line;

   // engine progress
   logic busy;
   logic [addr_w-1:0] src_addr;
   logic [addr_w-1:0] dst_addr;
   word_t x_count;
   word_t y_count;
   logic [3:0] line_number;
   logic first_word;
   logic last_word;
   logic src_load;
   logic dst_load;

   // interrupt is the busy level
   assign irq = busy;

   blit_regs #(.addr_w(addr_w)) u_regs (
      .clk(clk), .reset(reset), .sel(sel), .rw(rw), .addr(addr), .din(din),
      .uds(uds), .lds(lds), .dout(dout), .busy(busy), .line_number(line_number),
      .cur_src_addr(src_addr), .cur_dst_addr(dst_addr),
      .cur_x_count(x_count), .cur_y_count(y_count), .start(start),
      .src_x_inc(src_x_inc), .src_y_inc(src_y_inc),
      .dst_x_inc(dst_x_inc), .dst_y_inc(dst_y_inc),
      .src_addr_init(src_addr_init), .dst_addr_init(dst_addr_init),
      .x_count_init(x_count_init), .y_count_init(y_count_init),
      .line_init(line_init), .endmask1(endmask1), .endmask2(endmask2),
      .endmask3(endmask3), .hop(hop), .lop(lop), .skew(skew),
      .halftone_line(halftone_line)
   );

   blit_sequencer #(.addr_w(addr_w)) u_seq (
      .clk(clk), .reset(reset), .start(start),
      .src_x_inc(src_x_inc), .src_y_inc(src_y_inc),
      .dst_x_inc(dst_x_inc), .dst_y_inc(dst_y_inc),
      .src_addr_init(src_addr_init), .dst_addr_init(dst_addr_init),
      .x_count_init(x_count_init), .y_count_init(y_count_init),
      .line_init(line_init), .endmask1(endmask1), .endmask2(endmask2),
      .endmask3(endmask3), .hop(hop), .lop(lop), .busy(busy), .state(),
      .src_addr(src_addr), .dst_addr(dst_addr), .x_count(x_count),
      .y_count(y_count), .line_number(line_number),
      .first_word(first_word), .last_word(last_word), .bm_addr(bm_addr),
      .bm_read(bm_read), .bm_write(bm_write),
      .src_load(src_load), .dst_load(dst_load)
   );

   blit_datapath u_dp (
      .clk(clk), .reset(reset), .start(start), .src_load(src_load),
      .dst_load(dst_load), .src_x_neg(src_x_inc[14]), .bm_data_in(bm_data_in),
      .skew(skew), .hop(hop), .lop(lop), .halftone_line(halftone_line),
      .endmask1(endmask1), .endmask2(endmask2), .endmask3(endmask3),
      .first_word(first_word), .last_word(last_word),
      .bm_data_out(bm_data_out)
   );

endmodule

//--- sim/blit_model.svh
`ifndef blit_model_svh
`define blit_model_svh

// ----------------------------------------------------------------------
// reference blit on a model memory image
// ----------------------------------------------------------------------
// image of the bus memory after the blit, filled before each run
word_t model_mem [mem_words];
logic [22:0] model_src_end;
logic [22:0] model_dst_end;

// one logic op bit, truth table indexed by {~s, ~d}
function automatic logic lop_bit(logic [3:0] op, logic s, logic d);
   return op[{~s, ~d}];
endfunction

// returns the number of bus accesses, reads and writes together
function automatic int blit_model();
   logic [31:0] sbuf;
   word_t dlat;
   word_t s;
   word_t r;
   word_t m;
   logic [22:0] sa;
   logic [22:0] da;
   logic [3:0] ln;
   logic first;
   logic last;
   int x;
   int y;
   int n;
   sbuf = '0;
   dlat = '0;
   sa = p_src;
   da = p_dst;
   ln = p_line;
   n = 0;
   for (y = p_yc; y >= 1; y--) begin
      for (x = p_xc; x >= 1; x--) begin
         first = (x == p_xc);
         last = (x == 1);
         // first mask wins on a single word row
         m = first ? p_m1 : (last ? p_m3 : p_m2);
         if (!(hop_no_src(p_hop) || lop_no_src(p_lop))) begin
            if (p_sxi < 0)
               sbuf = {model_mem[sa[11:0]], sbuf[31:16]};
            else
               sbuf = {sbuf[15:0], model_mem[sa[11:0]]};
            sa = sa + 23'(last ? p_syi : p_sxi);
            n++;
         end
         if (!lop_no_dst(p_lop) || m != 16'hffff) begin
            dlat = model_mem[da[11:0]];
            n++;
         end
         case (p_hop)
            hop_ones:     s = 16'hffff;
            hop_halftone: s = p_ht[ln];
            hop_source:   s = 16'(sbuf >> p_skew);
            default:      s = p_ht[ln] & 16'(sbuf >> p_skew);
         endcase
         for (int b = 0; b < 16; b++)
            r[b] = lop_bit(p_lop, s[b], dlat[b]);
         model_mem[da[11:0]] = (r & m) | (dlat & ~m);
         n++;
         if (last) begin
            da = da + 23'(p_dyi);
            // halftone line walks with the destination rows
            ln = (p_dyi < 0) ? ln - 4'd1 : ln + 4'd1;
         end else begin
            da = da + 23'(p_dxi);
         end
      end
   end
   model_src_end = sa;
   model_dst_end = da;
   return n;
endfunction

`endif

//--- sim/blitter_tb.sv
`timescale 1ns/1ps

module blitter_tb;
   import blit_pkg::*;

   localparam int mem_words = 4096;
   // words per test group: copy, logic ops, halftone ops, end masks
   localparam int total_words = 12 + 16 * 15 + 4 * 16 + 3 * (1 + 2 + 6);
   localparam int blit_count = 1 + 16 + 4 + 3;
   localparam int worst_cycles = 3 * total_words + 80 * blit_count;

   logic clk;
   logic reset;
   logic sel;
   logic rw;
   reg_addr_t addr;
   word_t din;
   logic uds;
   logic lds;
   word_t dout;
   logic irq;
   logic [22:0] bm_addr;
   logic bm_read;
   logic bm_write;
   word_t bm_data_out;
   word_t bm_data_in;

   // bus memory and its fill control
   word_t mem [mem_words];
   logic fill_req;
   logic [31:0] fill_seed;
   int rd_total;
   int wr_total;
   logic [31:0] rng;

   // blit parameters shared by stimulus and model
   logic [22:0] p_src;
   logic [22:0] p_dst;
   int p_sxi;
   int p_syi;
   int p_dxi;
   int p_dyi;
   int p_xc;
   int p_yc;
   hop_t p_hop;
   lop_t p_lop;
   logic [3:0] p_skew;
   logic [3:0] p_line;
   word_t p_m1;
   word_t p_m2;
   word_t p_m3;
   word_t p_ht [16];

   `include "blit_model.svh"

   blitter_top #(.addr_w(23)) dut (
      .clk(clk), .reset(reset), .sel(sel), .rw(rw), .addr(addr), .din(din),
      .uds(uds), .lds(lds), .dout(dout), .irq(irq), .bm_addr(bm_addr),
      .bm_read(bm_read), .bm_write(bm_write), .bm_data_out(bm_data_out),
      .bm_data_in(bm_data_in)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   function automatic logic [31:0] xorshift(logic [31:0] x);
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // fill value mixes the full address with the seed
   function automatic word_t fill_word(logic [11:0] a, logic [31:0] s);
      logic [31:0] h;
      h = xorshift(s ^ ({20'h0, a} * 32'h9e3779b9) ^ {a, 20'h5a5a5});
      return h[15:0];
   endfunction

   function automatic word_t next_rand();
      rng = xorshift(rng);
      return rng[15:0];
   endfunction

   // memory answers in the read cycle, stores at the end of a write cycle
   assign bm_data_in = mem[bm_addr[11:0]];

   always @(posedge clk) begin
      if (fill_req) begin
         for (int i = 0; i < mem_words; i++)
            mem[i] <= fill_word(12'(i), fill_seed);
      end else if (bm_write) begin
         mem[bm_addr[11:0]] <= bm_data_out;
      end
   end

   // strobe counters, sampled mid cycle
   always @(negedge clk) begin
      if (bm_read && bm_write)
         stop_with_failure("bm_read and bm_write were high together");
      if (bm_read)
         rd_total <= rd_total + 1;
      if (bm_write)
         wr_total <= wr_total + 1;
   end

   // ------------------------------------------------------------------
   // failure reporting and compare tasks
   // ------------------------------------------------------------------
   task automatic stop_with_failure(string why);
      $display("%s", why);
      $display("FAIL: see errors above");
      $fatal(1);
   endtask

   task automatic check_word(word_t got, word_t exp, string what);
      if (got !== exp)
         stop_with_failure($sformatf("Mismatch at %0t: %s got %h expected %h",
                                     $time, what, got, exp));
   endtask

   task automatic check_flag(logic got, logic exp, string what);
      if (got !== exp)
         stop_with_failure($sformatf("Mismatch at %0t: %s got %b expected %b",
                                     $time, what, got, exp));
   endtask

   task automatic check_count(int got, int exp, string what);
      if (got != exp)
         stop_with_failure($sformatf("Mismatch at %0t: %s got %0d expected %0d",
                                     $time, what, got, exp));
   endtask

   initial begin
      #((worst_cycles * 3 + 16) * 4);
      stop_with_failure("timeout: a blit never finished within the time budget");
   end

   // ------------------------------------------------------------------
   // cpu bus tasks, each starts and ends just after a falling edge
   // ------------------------------------------------------------------
   task automatic cpu_write(reg_addr_t a, word_t d);
      sel = 1'b1;
      rw = 1'b0;
      addr = a;
      din = d;
      uds = 1'b0;
      lds = 1'b0;
      @(negedge clk);
      sel = 1'b0;
      rw = 1'b1;
      uds = 1'b1;
      lds = 1'b1;
   endtask

   task automatic cpu_read(reg_addr_t a, output word_t v);
      sel = 1'b1;
      rw = 1'b1;
      addr = a;
      #1;
      v = dout;
      @(negedge clk);
      sel = 1'b0;
   endtask

   task automatic program_blit();
      for (int i = 0; i < 16; i++)
         cpu_write(ht_base + reg_addr_t'(i), p_ht[i]);
      cpu_write(src_x_inc_reg, 16'(p_sxi * 2));
      cpu_write(src_y_inc_reg, 16'(p_syi * 2));
      cpu_write(dst_x_inc_reg, 16'(p_dxi * 2));
      cpu_write(dst_y_inc_reg, 16'(p_dyi * 2));
      cpu_write(src_addr_hi_reg, 16'(p_src >> 15));
      cpu_write(src_addr_lo_reg, {p_src[14:0], 1'b0});
      cpu_write(dst_addr_hi_reg, 16'(p_dst >> 15));
      cpu_write(dst_addr_lo_reg, {p_dst[14:0], 1'b0});
      cpu_write(endmask1_reg, p_m1);
      cpu_write(endmask2_reg, p_m2);
      cpu_write(endmask3_reg, p_m3);
      cpu_write(x_count_reg, 16'(p_xc));
      cpu_write(y_count_reg, 16'(p_yc));
      cpu_write(op_reg, {6'b0, p_hop, 4'b0, p_lop});
   endtask

   // fresh memory, program, start, poll busy, then compare everything
   task automatic run_blit(string name);
      int rd0;
      int wr0;
      int exp_n;
      logic done;
      word_t v;
      fill_seed = {next_rand(), next_rand()};
      fill_req = 1'b1;
      @(negedge clk);
      fill_req = 1'b0;
      for (int i = 0; i < mem_words; i++)
         model_mem[i] = fill_word(12'(i), fill_seed);
      program_blit();
      rd0 = rd_total;
      wr0 = wr_total;
      cpu_write(ctrl_reg, {1'b1, 3'b000, p_line, 4'b0000, p_skew});
      check_flag(irq, 1'b1, {name, ": irq after start"});
      done = 1'b0;
      while (!done) begin
         sel = 1'b1;
         rw = 1'b1;
         addr = ctrl_reg;
         #1;
         check_flag(irq, dout[15], {name, ": irq against busy"});
         done = !dout[15];
         @(negedge clk);
      end
      sel = 1'b0;
      exp_n = blit_model();
      check_count(rd_total - rd0 + wr_total - wr0, exp_n, {name, ": bus strobes"});
      for (int i = 0; i < mem_words; i++)
         check_word(mem[i], model_mem[i], $sformatf("%s memory word %h", name, i));
      cpu_read(src_addr_lo_reg, v);
      check_word(v, {model_src_end[14:0], 1'b0}, {name, ": final source address low"});
      cpu_read(src_addr_hi_reg, v);
      check_word(v, 16'(model_src_end >> 15), {name, ": final source address high"});
      cpu_read(dst_addr_lo_reg, v);
      check_word(v, {model_dst_end[14:0], 1'b0}, {name, ": final destination address low"});
      cpu_read(dst_addr_hi_reg, v);
      check_word(v, 16'(model_dst_end >> 15), {name, ": final destination address high"});
   endtask

   task automatic set_defaults();
      p_src = 23'h000100;
      p_dst = 23'h000400;
      p_sxi = 1;
      p_syi = 13;
      p_dxi = 1;
      p_dyi = 13;
      p_xc = 4;
      p_yc = 3;
      p_hop = hop_source;
      p_lop = lop_src;
      p_skew = 4'd0;
      p_line = 4'd0;
      p_m1 = 16'hffff;
      p_m2 = 16'hffff;
      p_m3 = 16'hffff;
      for (int i = 0; i < 16; i++)
         p_ht[i] = next_rand();
   endtask

   // ------------------------------------------------------------------
   // test sequence
   // ------------------------------------------------------------------
   initial begin
      word_t v;
      int widths [3];
      sel = 1'b0;
      rw = 1'b1;
      addr = '0;
      din = '0;
      uds = 1'b1;
      lds = 1'b1;
      fill_req = 1'b0;
      fill_seed = '0;
      rd_total = 0;
      wr_total = 0;
      rng = 32'd1961;
      reset = 1'b1;
      repeat (16) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;

      // idle state and register window
      check_flag(irq, 1'b0, "irq after reset");
      check_flag(bm_read, 1'b0, "bm_read after reset");
      check_flag(bm_write, 1'b0, "bm_write after reset");
      cpu_write(src_x_inc_reg, 16'hffff);
      cpu_read(src_x_inc_reg, v);
      check_word(v, 16'hfffe, "source x increment read back");
      cpu_write(src_addr_hi_reg, 16'hffff);
      cpu_read(src_addr_hi_reg, v);
      check_word(v, 16'h00ff, "source address high read back");
      cpu_write(op_reg, 16'hffff);
      cpu_read(op_reg, v);
      check_word(v, 16'h030f, "op register read back");
      cpu_write(ht_base + 5'd5, 16'h1234);
      cpu_read(ht_base + 5'd5, v);
      check_word(v, 16'h1234, "halftone word 5 read back");
      cpu_write(endmask2_reg, 16'ha5c3);
      cpu_read(endmask2_reg, v);
      check_word(v, 16'ha5c3, "end mask 2 read back");
      cpu_write(ctrl_reg, 16'h7fff);
      cpu_read(ctrl_reg, v);
      check_word(v, 16'h0f0f, "control read back");
      // zero rows means no blit
      cpu_write(y_count_reg, 16'h0000);
      cpu_write(ctrl_reg, 16'h8000);
      cpu_read(ctrl_reg, v);
      check_word(v, 16'h0000, "control after start with zero rows");
      check_flag(irq, 1'b0, "irq after start with zero rows");
      // no bus cycle while idle
      check_count(rd_total + wr_total, 0, "bus strobes before the first blit");

      // plain copy
      set_defaults();
      run_blit("copy");

      // every logic op, random skew, source walks backwards
      for (int op = 0; op < 16; op++) begin
         set_defaults();
         p_src = 23'h000904;
         p_sxi = -1;
         p_syi = 20;
         p_dst = 23'h000600;
         p_dyi = 12;
         p_xc = 5;
         p_lop = lop_t'(op);
         p_skew = 4'(next_rand());
         run_blit($sformatf("logic op %0d", op));
      end

      // halftone ops, rows walk downwards in memory
      for (int h = 0; h < 4; h++) begin
         set_defaults();
         p_dst = 23'h000c00;
         p_dyi = -20;
         p_xc = 4;
         p_yc = 4;
         p_hop = hop_t'(h);
         p_lop = lop_xor;
         p_line = 4'd2 + 4'(h);
         p_skew = 4'(h * 3);
         run_blit($sformatf("halftone op %0d", h));
      end

      // partial end masks on narrow and wide rows
      widths[0] = 1;
      widths[1] = 2;
      widths[2] = 6;
      foreach (widths[k]) begin
         set_defaults();
         p_xc = widths[k];
         p_syi = 10;
         p_dyi = 10;
         p_lop = lop_or;
         p_m1 = next_rand();
         p_m2 = next_rand();
         p_m3 = next_rand();
         run_blit($sformatf("end masks width %0d", widths[k]));
      end

      $display("PASS: all tests");
      $finish;
   end

endmodule

//--- sources.f
+incdir+sim
rtl/blit_pkg.sv
rtl/blit_regs.sv
rtl/blit_sequencer.sv
rtl/blit_datapath.sv
rtl/blitter_top.sv
sim/blitter_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build the blitter testbench with Verilator, run it, and judge the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal -f sources.f --top-module blitter_tb \
   -o blitter_sim > build.log 2>&1 \
   && ./obj_dir/blitter_sim > sim.log 2>&1 \
   || echo "build or simulation returned an error, see build.log and sim.log"
grep -qx "PASS: all tests" sim.log && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }
